// ==== rtl/rom_pkg.sv ====
// shared widths, region map and handshake types for the ROM fetch caches and arbiter
package rom_pkg;

    // clients, listed in arbitration priority order (lowest value wins)
    typedef enum logic [1:0] {
        client_snd  = 2'd0,
        client_obj  = 2'd1,
        client_char = 2'd2,
        client_main = 2'd3
    } client_e;

    localparam int NUM_CLIENTS = 4;

    // SDRAM side, 32-bit words
    localparam int SDRAM_AW = 22;
    localparam int SDRAM_DW = 32;

    // client address widths
    localparam int MAIN_AW = 18;  // bytes
    localparam int SND_AW  = 15;  // bytes
    localparam int CHAR_AW = 14;  // halfwords
    localparam int OBJ_AW  = 17;  // halfwords

    // region placement in SDRAM word space
    // main  64k words   0x00000 - 0x0ffff
    // snd    8k words   0x10000 - 0x11fff
    // char   8k words   0x12000 - 0x13fff
    // obj   64k words   0x14000 - 0x23fff
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = 22'h01_0000;
    localparam logic [SDRAM_AW-1:0] CHAR_OFFSET = 22'h01_2000;
    localparam logic [SDRAM_AW-1:0] OBJ_OFFSET  = 22'h01_4000;

    // stripes on the tile layer until the game ROM is in place
    localparam logic [15:0] CHAR_BLANK = 16'hAAAA;

    localparam int READY_DELAY = 5;  // clocks from idle to ready

    // cache miss request, word_addr is relative to the client region
    typedef struct packed {
        logic                req;
        logic [SDRAM_AW-1:0] word_addr;
    } client_req_t;

    // read return from the SDRAM controller, broadcast to all caches
    typedef struct packed {
        logic                rdy;
        logic [SDRAM_DW-1:0] data;
    } sdram_rsp_t;

    // one-hot, bit n set while client n owns the outstanding read
    typedef logic [NUM_CLIENTS-1:0] client_sel_t;

endpackage

// ==== rtl/rom_word_cache.sv ====
// single-word ROM cache that rom_fetch_top instantiates once per game client

`timescale 1ns/1ps

module rom_word_cache #(
    parameter int DW = 8,   // 8 for byte clients, 16 for halfword clients
    parameter int AW = 18
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    input  logic                 load,    // this cache owns the current read
    input  rom_pkg::sdram_rsp_t  rsp,
    output rom_pkg::client_req_t creq,
    output logic [DW-1:0]        dout,
    output logic                 ok
);

    // slice select bits inside a 32-bit word
    localparam int SW = (DW == 8) ? 2 : 1;
    // word index width
    localparam int WW = AW - SW;

    logic [WW-1:0]                word_idx;
    logic [SW-1:0]                slice;
    logic                         hit;
    logic                         fill;

    logic                         valid;
    logic                         pend;      // miss issued, waiting for data
    logic [WW-1:0]                pend_idx;  // word index frozen at the miss
    logic [WW-1:0]                req_idx;

    logic [rom_pkg::SDRAM_DW-1:0] cached_word;
    logic [WW-1:0]                cached_idx;

    assign word_idx = addr[AW-1:SW];
    assign slice    = addr[SW-1:0];

    assign hit  = valid && (cached_idx == word_idx);
    assign fill = load && rsp.rdy;

    // once a miss is out the index must not follow addr any more
    assign req_idx = pend ? pend_idx : word_idx;

    assign creq.req       = pend || (cs && !hit);
    assign creq.word_addr = {{(rom_pkg::SDRAM_AW - WW){1'b0}}, req_idx};

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            pend  <= 1'b0;
        end else if (fill) begin
            valid <= 1'b1;
            pend  <= 1'b0;
        end else if (creq.req) begin
            pend <= 1'b1;  // held until the word lands
        end
    end

    // captured index of the miss being served
    always_ff @(posedge clk) begin
        if (creq.req && !pend) begin
            pend_idx <= word_idx;
        end
    end

    // cached word and its index
    always_ff @(posedge clk) begin
        if (fill) begin
            cached_word <= rsp.data;
            cached_idx  <= req_idx;
        end
    end

    // slice 0 sits in the low bits of the word
    assign dout = cached_word[int'(slice) * DW +: DW];

    assign ok = hit;  // same cycle on a hit, one clock after data_rdy on a miss

endmodule

// ==== rtl/rom_fetch_arbiter.sv ====
// fixed-priority SDRAM read arbiter and idle control used inside rom_fetch_top

`timescale 1ns/1ps

module rom_fetch_arbiter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          downloading,
    input  rom_pkg::client_req_t          reqs [rom_pkg::NUM_CLIENTS],
    input  logic                          sdram_ack,
    input  rom_pkg::sdram_rsp_t           rsp,
    output rom_pkg::client_sel_t          sel,
    output logic                          sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0]  sdram_addr,
    output logic                          ready,
    output logic                          refresh_en,
    output logic                          download_done
);

    logic                         clear;      // reset or ROM download in progress
    logic                         free;       // a new read may be granted
    rom_pkg::client_sel_t         req_vec;
    rom_pkg::client_sel_t         grant;
    logic                         any_grant;
    logic [rom_pkg::SDRAM_AW-1:0] grant_addr;

    logic [rom_pkg::READY_DELAY-2:0] ready_cnt;
    logic                            dl_last;

    // region base for each client
    function automatic logic [rom_pkg::SDRAM_AW-1:0] region_offset(
        input rom_pkg::client_e c
    );
        case (c)
            rom_pkg::client_snd:  return rom_pkg::SND_OFFSET;
            rom_pkg::client_obj:  return rom_pkg::OBJ_OFFSET;
            rom_pkg::client_char: return rom_pkg::CHAR_OFFSET;
            default:              return rom_pkg::MAIN_OFFSET;
        endcase
    endfunction

    assign clear = reset || downloading;

    // nothing outstanding, or the outstanding word arrives this cycle
    assign free = (sel == '0) || rsp.rdy;

    always_comb begin
        for (int i = 0; i < rom_pkg::NUM_CLIENTS; i++) begin
            req_vec[i] = reqs[i].req;
        end
    end

    // walk from the bottom up so the lowest index ends up as the winner
    always_comb begin
        grant      = '0;
        grant_addr = '0;
        for (int i = rom_pkg::NUM_CLIENTS - 1; i >= 0; i--) begin
            if (reqs[i].req && !sel[i]) begin  // skip the client being served
                grant      = '0;
                grant[i]   = 1'b1;
                grant_addr = region_offset(rom_pkg::client_e'(i)) + reqs[i].word_addr;
            end
        end
    end

    assign any_grant = |grant;

    // request and ownership
    always_ff @(posedge clk) begin
        if (clear) begin
            sdram_req <= 1'b0;
            sel       <= '0;
        end else begin
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (free) begin
                sel <= grant;  // zero when nobody is waiting
                if (any_grant) begin
                    sdram_req <= 1'b1;
                end
            end
        end
    end

    // address only moves with a new grant, so it is stable until ack
    always_ff @(posedge clk) begin
        if (!clear && free && any_grant) begin
            sdram_addr <= grant_addr;
        end
    end

    // shift in ones after idle starts with ready as the last stage
    always_ff @(posedge clk) begin
        if (clear) begin
            ready_cnt <= '0;
            ready     <= 1'b0;
        end else begin
            {ready, ready_cnt} <= {ready_cnt, 1'b1};
        end
    end

    // download completes on the falling edge of downloading
    always_ff @(posedge clk) begin
        if (reset) begin
            dl_last       <= 1'b0;
            download_done <= 1'b0;
        end else begin
            dl_last <= downloading;
            if (dl_last && !downloading) begin
                download_done <= 1'b1;  // sticky until reset
            end
        end
    end

    // let the controller refresh only while the bus is truly idle
    always_ff @(posedge clk) begin
        if (reset) begin
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= (sel == '0) && (req_vec == '0);
        end
    end

endmodule

// ==== rtl/rom_fetch_top.sv ====
// ROM fetch top level; four client caches share one SDRAM read port through the arbiter

`timescale 1ns/1ps

module rom_fetch_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          downloading,

    input  logic                          main_cs,
    input  logic [rom_pkg::MAIN_AW-1:0]   main_addr,
    input  logic                          snd_cs,
    input  logic [rom_pkg::SND_AW-1:0]    snd_addr,
    input  logic                          char_cs,
    input  logic [rom_pkg::CHAR_AW-1:0]   char_addr,
    input  logic                          obj_cs,
    input  logic [rom_pkg::OBJ_AW-1:0]    obj_addr,

    output logic [7:0]                    main_dout,
    output logic [7:0]                    snd_dout,
    output logic [15:0]                   char_dout,
    output logic [15:0]                   obj_dout,
    output logic                          main_ok,
    output logic                          snd_ok,
    output logic                          char_ok,
    output logic                          obj_ok,

    output logic                          ready,
    output logic                          refresh_en,

    output logic                          sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0]  sdram_addr,
    input  logic                          sdram_ack,
    input  logic                          data_rdy,
    input  logic [rom_pkg::SDRAM_DW-1:0]  data_read
);

    rom_pkg::client_req_t reqs [rom_pkg::NUM_CLIENTS];
    rom_pkg::client_sel_t sel;
    rom_pkg::sdram_rsp_t  rsp;
    logic                 cache_reset;
    logic                 download_done;
    logic [15:0]          char_pre;

    assign rsp.rdy  = data_rdy;
    assign rsp.data = data_read;

    // caches drop their contents while a new ROM is loaded
    assign cache_reset = reset || downloading;

    rom_word_cache #(.DW(8), .AW(rom_pkg::MAIN_AW)) u_main (
        .clk   (clk),
        .reset (cache_reset),
        .cs    (main_cs),
        .addr  (main_addr),
        .load  (sel[rom_pkg::client_main]),
        .rsp   (rsp),
        .creq  (reqs[rom_pkg::client_main]),
        .dout  (main_dout),
        .ok    (main_ok)
    );

    rom_word_cache #(.DW(8), .AW(rom_pkg::SND_AW)) u_snd (
        .clk   (clk),
        .reset (cache_reset),
        .cs    (snd_cs),
        .addr  (snd_addr),
        .load  (sel[rom_pkg::client_snd]),
        .rsp   (rsp),
        .creq  (reqs[rom_pkg::client_snd]),
        .dout  (snd_dout),
        .ok    (snd_ok)
    );

    rom_word_cache #(.DW(16), .AW(rom_pkg::CHAR_AW)) u_char (
        .clk   (clk),
        .reset (cache_reset),
        .cs    (char_cs),
        .addr  (char_addr),
        .load  (sel[rom_pkg::client_char]),
        .rsp   (rsp),
        .creq  (reqs[rom_pkg::client_char]),
        .dout  (char_pre),
        .ok    (char_ok)
    );

    rom_word_cache #(.DW(16), .AW(rom_pkg::OBJ_AW)) u_obj (
        .clk   (clk),
        .reset (cache_reset),
        .cs    (obj_cs),
        .addr  (obj_addr),
        .load  (sel[rom_pkg::client_obj]),
        .rsp   (rsp),
        .creq  (reqs[rom_pkg::client_obj]),
        .dout  (obj_dout),
        .ok    (obj_ok)
    );

    rom_fetch_arbiter u_arb (
        .clk           (clk),
        .reset         (reset),
        .downloading   (downloading),
        .reqs          (reqs),
        .sdram_ack     (sdram_ack),
        .rsp           (rsp),
        .sel           (sel),
        .sdram_req     (sdram_req),
        .sdram_addr    (sdram_addr),
        .ready         (ready),
        .refresh_en    (refresh_en),
        .download_done (download_done)
    );

    // blank pattern until a ROM has been loaded
    // note char_dout trails the char cache, and char_ok, by one clock
    always_ff @(posedge clk) begin
        char_dout <= download_done ? char_pre : rom_pkg::CHAR_BLANK;
    end

endmodule

// ==== test/sdram_rom_model.sv ====
// behavioural SDRAM read port for the ROM fetch testbench; acks and returns words with random delays

`timescale 1ns/1ps

module sdram_rom_model #(
    parameter logic [31:0] SEED = 32'h13f
) (
    input  logic        clk,
    input  logic        long_delays,  // stretch both ack and data latency
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    logic [31:0] state;
    logic [21:0] addr;
    logic [31:0] a32;
    int          ack_wait;
    int          data_wait;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        state     = SEED;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #1;
            if (sdram_req) begin
                addr     = sdram_addr;
                state    = xorshift(state);
                ack_wait = int'(state[1:0]) + (long_delays ? 4 : 0);
                state    = xorshift(state);
                data_wait = int'(state[1:0]) + (long_delays ? 4 : 0);  // extra beyond 1
                repeat (ack_wait) begin
                    @(posedge clk);
                    #1;
                end
                sdram_ack = 1'b1;
                @(posedge clk);
                #1;
                sdram_ack = 1'b0;
                repeat (data_wait) begin
                    @(posedge clk);
                    #1;
                end
                a32       = {10'd0, addr};
                data_read = (a32 * 32'h9e3779b1) ^ a32;  // ROM content rule
                data_rdy  = 1'b1;
                @(posedge clk);
                #1;
                data_rdy = 1'b0;
            end
        end
    end

endmodule

// ==== test/rom_fetch_chk.sv ====
// SDRAM handshake assertions, bound into every rom_fetch_arbiter instance

`timescale 1ns/1ps

module rom_fetch_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 downloading,
    input logic                 sdram_req,
    input logic [21:0]          sdram_addr,
    input logic                 sdram_ack,
    input rom_pkg::client_sel_t sel
);

    // request and address hold until the controller takes them
    req_hold: assert property (@(posedge clk) disable iff (reset || downloading)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram request or address moved before ack");

    sel_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(sel))
        else $error("more than one client owns the read");

    // first clock of downloading may still show the old request
    dl_quiet: assert property (@(posedge clk) disable iff (reset)
        downloading && $past(downloading) |-> !sdram_req)
        else $error("sdram request raised during ROM download");

endmodule

bind rom_fetch_arbiter rom_fetch_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .downloading (downloading),
    .sdram_req   (sdram_req),
    .sdram_addr  (sdram_addr),
    .sdram_ack   (sdram_ack),
    .sel         (sel)
);

// ==== test/rom_fetch_tb.sv ====
// testbench for rom_fetch_top; drives the four clients against the SDRAM model and checks data

`timescale 1ns/1ps

module rom_fetch_tb;

    localparam int MAX_CYCLES = 200 * 16 + 100;

    logic clk = 1'b0;
    logic reset, downloading, long_delays;
    logic main_cs, snd_cs, char_cs, obj_cs;
    logic [17:0] main_addr;
    logic [14:0] snd_addr;
    logic [13:0] char_addr;
    logic [16:0] obj_addr;
    logic [7:0]  main_dout, snd_dout;
    logic [15:0] char_dout, obj_dout;
    logic main_ok, snd_ok, char_ok, obj_ok, ready, refresh_en;
    logic sdram_req, sdram_ack, data_rdy;
    logic [21:0] sdram_addr;
    logic [31:0] data_read;

    logic [31:0] rnd;
    logic        loaded;        // a ROM download has completed
    logic [17:0] chk_addr [4];  // address under test per client
    int          want [4];      // accesses issued per client
    int          seen [4];      // accesses checked per client
    logic        char_wait;
    logic [21:0] fetch_log [512];
    int          n_fetch;
    logic        req_q, dl_q, busy;
    int          cycles;
    int          data_errs, seq_errs, flow_errs;

    always #10 clk = ~clk;

    rom_fetch_top DUT (.*);

    sdram_rom_model #(.SEED(32'h13f)) u_sdram (
        .clk(clk), .long_delays(long_delays), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // client numbering follows arbitration priority: snd, obj, char, main
    function automatic logic [17:0] addr_mask(input int c);
        case (c)
            0: return 18'h07fff;
            1: return 18'h1ffff;
            2: return 18'h03fff;
            default: return 18'h3ffff;
        endcase
    endfunction

    function automatic logic [21:0] fetch_addr(input int c, input logic [17:0] a);
        logic [17:0] idx;
        idx = (c == 0 || c == 3) ? (a >> 2) : (a >> 1);  // byte or halfword client
        case (c)
            0: return rom_pkg::SND_OFFSET + {4'd0, idx};
            1: return rom_pkg::OBJ_OFFSET + {4'd0, idx};
            2: return rom_pkg::CHAR_OFFSET + {4'd0, idx};
            default: return rom_pkg::MAIN_OFFSET + {4'd0, idx};
        endcase
    endfunction

    // expected client data from the ROM content rule
    function automatic logic [15:0] rom_expect(input int c, input logic [17:0] a);
        logic [31:0] a32;
        logic [31:0] w;
        a32 = {10'd0, fetch_addr(c, a)};
        w   = (a32 * 32'h9e3779b1) ^ a32;
        if (c == 0 || c == 3) begin
            w = w >> ({3'd0, a[1:0]} * 5'd8);
            return {8'h00, w[7:0]};
        end
        w = a[0] ? (w >> 16) : w;
        return w[15:0];
    endfunction

    function automatic logic get_ok(input int c);
        case (c)
            0: return snd_ok;
            1: return obj_ok;
            2: return char_ok;
            default: return main_ok;
        endcase
    endfunction

    function automatic logic [15:0] get_dout(input int c);
        case (c)
            0: return {8'h00, snd_dout};
            1: return obj_dout;
            2: return char_dout;
            default: return {8'h00, main_dout};
        endcase
    endfunction

    task automatic drive(input int c, input logic en, input logic [17:0] a);
        case (c)
            0: begin
                snd_cs   = en;
                snd_addr = a[14:0];
            end
            1: begin
                obj_cs   = en;
                obj_addr = a[16:0];
            end
            2: begin
                char_cs   = en;
                char_addr = a[13:0];
            end
            default: begin
                main_cs   = en;
                main_addr = a;
            end
        endcase
    endtask

    // hold the address until the compare process has checked it
    task automatic access(input int c, input logic [17:0] a);
        @(posedge clk);
        #1;
        chk_addr[c] = a;
        drive(c, 1'b1, a);
        want[c]++;
        while (seen[c] != want[c]) @(posedge clk);
        #1 drive(c, 1'b0, a);
    endtask

    // compare at ok and char one clock later since char_dout is registered
    always @(negedge clk) begin
        logic [15:0] exp;
        for (int c = 0; c < 4; c++) begin
            if (seen[c] != want[c] && get_ok(c)) begin
                if (c == 2 && !char_wait) begin
                    char_wait = 1'b1;
                end else begin
                    if (c == 2) char_wait = 1'b0;
                    exp = (c == 2 && !loaded) ? rom_pkg::CHAR_BLANK : rom_expect(c, chk_addr[c]);
                    if (get_dout(c) !== exp) begin
                        data_errs++;
                        $display("ERR %0t: client %0d addr %h read %h expected %h",
                                 $time, c, chk_addr[c], get_dout(c), exp);
                    end
                    seen[c]++;
                end
            end
        end
    end

    // SDRAM traffic log plus refresh and download checks
    always @(negedge clk) begin
        if (!reset) begin
            if (sdram_req && !req_q && n_fetch < 512) begin
                fetch_log[n_fetch] = sdram_addr;
                n_fetch++;
            end
            req_q = sdram_req;
            if (sdram_req) busy = 1'b1;
            if (refresh_en && busy) begin
                flow_errs++;
                $display("ERR %0t: refresh_en high with a fetch pending", $time);
            end
            if (dl_q && downloading &&
                (sdram_req || ready || main_ok || snd_ok || char_ok || obj_ok)) begin
                flow_errs++;
                $display("ERR %0t: activity during download", $time);
            end
            dl_q = downloading;
            if (data_rdy) busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [17:0] a;
        logic [17:0] smask;
        int start;
        int c;
        reset = 1'b1;
        downloading = 1'b0;
        long_delays = 1'b0;
        loaded = 1'b0;
        main_cs = 1'b0;
        snd_cs = 1'b0;
        char_cs = 1'b0;
        obj_cs = 1'b0;
        main_addr = '0;
        snd_addr = '0;
        char_addr = '0;
        obj_addr = '0;
        rnd = 32'h13f;
        char_wait = 1'b0;
        n_fetch = 0;
        req_q = 1'b0;
        dl_q = 1'b0;
        busy = 1'b0;
        cycles = 0;
        data_errs = 0;
        seq_errs = 0;
        flow_errs = 0;
        for (int i = 0; i < 4; i++) begin
            want[i] = 0;
            seen[i] = 0;
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        for (int k = 1; k <= 5; k++) begin
            @(posedge clk);
            #1;
            if (ready !== (k == 5)) begin
                seq_errs++;
                $display("ERR %0t: ready is %b at cycle %0d after reset", $time, ready, k);
            end
        end
        // one miss per client while char is still blank
        for (int i = 0; i < 4; i++) begin
            rnd = xorshift(rnd);
            a = rnd[17:0] & addr_mask(i);
            start = n_fetch;
            access(i, a);
            if (n_fetch != start + 1 || fetch_log[start] !== fetch_addr(i, a)) begin
                seq_errs++;
                $display("ERR %0t: client %0d fetch address wrong", $time, i);
            end
            // every slice of the same word hits
            start = n_fetch;
            smask = (i == 0 || i == 3) ? 18'h3 : 18'h1;
            for (int s = 0; s < 4; s++) begin
                access(i, (a & ~smask) | (18'(s) & smask));
            end
            if (n_fetch != start) begin
                seq_errs++;
                $display("ERR %0t: client %0d refetched on a hit", $time, i);
            end
        end
        @(posedge clk);
        #1 downloading = 1'b1;
        drive(1, 1'b1, 18'h00010);  // obj misses while the ROM loads
        repeat (10) @(posedge clk);
        #1 drive(1, 1'b0, 18'h00010);
        downloading = 1'b0;
        repeat (3) @(posedge clk);
        loaded = 1'b1;
        // all four miss together
        start = n_fetch;
        fork
            access(0, 18'h00123 & addr_mask(0));
            access(1, 18'h0a456 & addr_mask(1));
            access(2, 18'h01789 & addr_mask(2));
            access(3, 18'h2abcd);
        join
        for (int i = 0; i < 4; i++) begin
            if (n_fetch != start + 4 || fetch_log[start + i] !== fetch_addr(i,
                i == 0 ? 18'h00123 : i == 1 ? 18'h0a456 : i == 2 ? 18'h01789 : 18'h2abcd)) begin
                seq_errs++;
                $display("ERR %0t: fetch %0d out of priority order", $time, i);
            end
        end
        for (int i = 0; i < 150; i++) begin
            long_delays = (i >= 75);
            rnd = xorshift(rnd);
            c = int'(rnd[1:0]);
            rnd = xorshift(rnd);
            access(c, rnd[17:0] & addr_mask(c));
        end
        repeat (4) @(posedge clk);
        #1;
        if (!refresh_en) begin
            seq_errs++;
            $display("ERR %0t: refresh_en low while idle", $time);
        end
        $display("errors: data %0d, sequence %0d, bus %0d", data_errs, seq_errs, flow_errs);
        if (data_errs + seq_errs + flow_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== rom_fetch_top.f ====
rtl/rom_pkg.sv
rtl/rom_word_cache.sv
rtl/rom_fetch_arbiter.sv
rtl/rom_fetch_top.sv
test/sdram_rom_model.sv
test/rom_fetch_chk.sv
test/rom_fetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the ROM fetch testbench

VERILATOR ?= verilator
TOP       ?= rom_fetch_tb
FLIST     ?= rom_fetch_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
